//--- verilog/exec_pkg.sv
package exec_pkg;

  // datapath and register file sizes
  localparam int xlen  = 32;
  localparam int nreg  = 16;
  localparam int reg_w = 4;

  // issue queue sizes
  localparam int iq_depth = 8;
  localparam int iq_idx_w = 3;

  typedef logic [xlen-1:0]  data_t;
  typedef logic [reg_w-1:0] reg_idx_t;

  // alu function codes
  typedef enum logic [3:0] {
    op_add   = 4'd0,
    op_sub   = 4'd1,
    op_and   = 4'd2,
    op_xor   = 4'd3,
    op_or    = 4'd4,
    op_shl   = 4'd5,
    op_shr   = 4'd6,
    op_sar   = 4'd7,
    op_sxtb  = 4'd8,
    op_sxth  = 4'd9,
    op_bswap = 4'd10,
    op_movi  = 4'd11
  } alu_op_t;

  // result flags, carry and overflow only meaningful for add/sub
  typedef struct packed {
    logic carry;
    logic sign;
    logic zero;
    logic overflow;
  } flags_t;

endpackage

//--- verilog/issue_if.sv
interface issue_if;

  logic              valid;  // one cycle per issued entry
  exec_pkg::alu_op_t op;
  exec_pkg::data_t   a_val;
  exec_pkg::data_t   b_val;  // register value or immediate
  exec_pkg::reg_idx_t dst;

  modport queue (
    output valid,
    output op,
    output a_val,
    output b_val,
    output dst
  );

  modport alu (
    input valid,
    input op,
    input a_val,
    input b_val,
    input dst
  );

endinterface

//--- verilog/wb_if.sv
interface wb_if;

  logic               valid;
  exec_pkg::reg_idx_t dst;
  exec_pkg::data_t    data;
  exec_pkg::flags_t   flags;

  modport src (output valid, output dst, output data, output flags);

  // register file side
  modport reg_side (input valid, input dst, input data);

  // queue wakeup snoops tag and data
  modport snoop (input valid, input dst, input data);

endinterface

//--- verilog/reg_state.sv
module reg_state (
  input  logic               clk,
  input  logic               rst,
  input  exec_pkg::reg_idx_t rd_a_addr,
  input  exec_pkg::reg_idx_t rd_b_addr,
  output exec_pkg::data_t    rd_a_data,
  output exec_pkg::data_t    rd_b_data,
  output logic               rd_a_pending,
  output logic               rd_b_pending,
  input  logic               alloc,
  input  exec_pkg::reg_idx_t alloc_reg,
  output logic               alloc_pending,
  wb_if.reg_side             wb
);

  import exec_pkg::*;

  data_t           regs [nreg];
  logic [nreg-1:0] pending;  // result outstanding

  assign rd_a_data    = regs[rd_a_addr];
  assign rd_b_data    = regs[rd_b_addr];
  assign rd_a_pending = pending[rd_a_addr];
  assign rd_b_pending = pending[rd_b_addr];

  // also covers the writeback cycle itself
  assign alloc_pending = pending[alloc_reg];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < nreg; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid) begin
      regs[wb.dst] <= wb.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (wb.valid) pending[wb.dst] <= 1'b0;
      // alloc last so a same-edge set wins
      if (alloc) pending[alloc_reg] <= 1'b1;
    end
  end

  // every result returning from the alu was allocated earlier
  a_wb_to_pending: assert property (
    @(posedge clk) disable iff (rst)
    wb.valid |-> pending[wb.dst]
  );

endmodule

//--- verilog/issue_queue.sv
module issue_queue (
  input  logic               clk,
  input  logic               rst,
  input  logic               insert,
  input  exec_pkg::alu_op_t  op,
  input  exec_pkg::reg_idx_t src_a,
  input  exec_pkg::reg_idx_t src_b,
  input  exec_pkg::reg_idx_t dst,
  input  exec_pkg::data_t    imm,
  input  logic               use_imm,
  output logic               busy,
  output exec_pkg::reg_idx_t rd_a_addr,
  output exec_pkg::reg_idx_t rd_b_addr,
  input  exec_pkg::data_t    rd_a_data,
  input  exec_pkg::data_t    rd_b_data,
  input  logic               rd_a_pending,
  input  logic               rd_b_pending,
  output logic               alloc,
  output exec_pkg::reg_idx_t alloc_reg,
  input  logic               alloc_pending,
  wb_if.snoop                wb,
  issue_if.queue             iss
);

  import exec_pkg::*;

  logic [iq_depth-1:0] valid_q;
  logic [iq_depth-1:0] a_rdy;
  logic [iq_depth-1:0] b_rdy;
  alu_op_t             ent_op  [iq_depth];
  reg_idx_t            ent_dst [iq_depth];
  reg_idx_t            a_tag   [iq_depth];
  reg_idx_t            b_tag   [iq_depth];
  data_t               a_val   [iq_depth];
  data_t               b_val   [iq_depth];

  logic                free_hit;
  logic [iq_idx_w-1:0] free_idx;
  logic                issue_hit;
  logic [iq_idx_w-1:0] issue_idx;

  data_t ins_a_val;
  data_t ins_b_val;
  logic  ins_a_rdy;
  logic  ins_b_rdy;

  assign rd_a_addr = src_a;
  assign rd_b_addr = src_b;
  assign alloc_reg = dst;

  // full queue or waw on the incoming destination
  assign busy  = !free_hit || alloc_pending;
  assign alloc = insert && !busy;

  // operand capture at insert, with bypass from a same-cycle writeback
  always_comb begin
    ins_a_val = rd_a_data;
    ins_a_rdy = 1'b1;
    if (rd_a_pending) begin
      if (wb.valid && wb.dst == src_a) begin
        ins_a_val = wb.data;
      end else begin
        ins_a_rdy = 1'b0;
      end
    end
    ins_b_val = rd_b_data;
    ins_b_rdy = 1'b1;
    if (use_imm) begin
      ins_b_val = imm;
    end else if (rd_b_pending) begin
      if (wb.valid && wb.dst == src_b) begin
        ins_b_val = wb.data;
      end else begin
        ins_b_rdy = 1'b0;
      end
    end
  end

  // lowest-index finders, scanned downward so the lowest hit is kept
  always_comb begin
    free_hit  = 1'b0;
    free_idx  = '0;
    issue_hit = 1'b0;
    issue_idx = '0;
    for (int i = iq_depth - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_hit = 1'b1;
        free_idx = iq_idx_w'(i);
      end
      if (valid_q[i] && a_rdy[i] && b_rdy[i]) begin
        issue_hit = 1'b1;
        issue_idx = iq_idx_w'(i);
      end
    end
  end

  assign iss.valid = issue_hit;
  assign iss.op    = ent_op[issue_idx];
  assign iss.a_val = a_val[issue_idx];
  assign iss.b_val = b_val[issue_idx];
  assign iss.dst   = ent_dst[issue_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      a_rdy   <= '0;
      b_rdy   <= '0;
    end else begin
      for (int i = 0; i < iq_depth; i++) begin
        if (wb.valid && !a_rdy[i] && a_tag[i] == wb.dst) a_rdy[i] <= 1'b1;  // wakeup
        if (wb.valid && !b_rdy[i] && b_tag[i] == wb.dst) b_rdy[i] <= 1'b1;
      end
      if (issue_hit) valid_q[issue_idx] <= 1'b0;
      if (alloc) begin
        valid_q[free_idx] <= 1'b1;
        a_rdy[free_idx]   <= ins_a_rdy;
        b_rdy[free_idx]   <= ins_b_rdy;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < iq_depth; i++) begin
      if (wb.valid && !a_rdy[i] && a_tag[i] == wb.dst) a_val[i] <= wb.data;
      if (wb.valid && !b_rdy[i] && b_tag[i] == wb.dst) b_val[i] <= wb.data;
    end
    if (alloc) begin
      ent_op[free_idx]  <= op;
      ent_dst[free_idx] <= dst;
      a_tag[free_idx]   <= src_a;
      b_tag[free_idx]   <= src_b;
      a_val[free_idx]   <= ins_a_val;
      b_val[free_idx]   <= ins_b_val;
    end
  end

  a_no_insert_busy: assert property (
    @(posedge clk) disable iff (rst)
    insert |-> !busy
  );

  // issued entry is freed, so it cannot issue again next cycle
  a_issue_once: assert property (
    @(posedge clk) disable iff (rst)
    issue_hit |=> !(issue_hit && issue_idx == $past(issue_idx))
  );

endmodule

//--- verilog/alu.sv
module alu (
  input  logic  clk,
  input  logic  rst,
  issue_if.alu  iss,
  wb_if.src     wb
);

  import exec_pkg::*;

  data_t        a;
  data_t        b;
  logic [xlen:0] sum_ext;   // carry in top bit
  logic [xlen:0] diff_ext;
  data_t        res;
  flags_t       flg;

  assign a = iss.a_val;
  assign b = iss.b_val;

  assign sum_ext  = {1'b0, a} + {1'b0, b};
  assign diff_ext = {1'b0, a} + {1'b0, ~b} + 1'b1;

  always_comb begin
    res          = '0;
    flg.carry    = 1'b0;
    flg.overflow = 1'b0;
    case (iss.op)
      op_add: begin
        res          = sum_ext[xlen-1:0];
        flg.carry    = sum_ext[xlen];
        flg.overflow = (a[xlen-1] == b[xlen-1]) && (res[xlen-1] != a[xlen-1]);
      end
      op_sub: begin
        res          = diff_ext[xlen-1:0];
        flg.carry    = diff_ext[xlen];  // set when no borrow
        flg.overflow = (a[xlen-1] != b[xlen-1]) && (res[xlen-1] != a[xlen-1]);
      end
      op_and:   res = a & b;
      op_xor:   res = a ^ b;
      op_or:    res = a | b;
      op_shl:   res = a << b[4:0];
      op_shr:   res = a >> b[4:0];
      op_sar:   res = data_t'($signed(a) >>> b[4:0]);
      op_sxtb:  res = {{24{a[7]}}, a[7:0]};
      op_sxth:  res = {{16{a[15]}}, a[15:0]};
      op_bswap: res = {a[7:0], a[15:8], a[23:16], a[31:24]};
      op_movi:  res = b;
      default:  res = '0;
    endcase
    flg.zero = (res == '0);
    flg.sign = res[xlen-1];
  end

  // writeback stage
  always_ff @(posedge clk) begin
    if (rst) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= iss.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (iss.valid) begin
      wb.dst   <= iss.dst;
      wb.data  <= res;
      wb.flags <= flg;
    end
  end

  a_wb_valid_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(wb.valid)
  );

endmodule

//--- verilog/exec_core.sv
module exec_core (
  input  logic               clk,
  input  logic               rst,
  input  logic               insert,
  input  exec_pkg::alu_op_t  op,
  input  exec_pkg::reg_idx_t src_a,
  input  exec_pkg::reg_idx_t src_b,
  input  exec_pkg::reg_idx_t dst,
  input  exec_pkg::data_t    imm,
  input  logic               use_imm,
  output logic               busy,
  output logic               wb_valid,
  output exec_pkg::reg_idx_t wb_reg,
  output exec_pkg::data_t    wb_data,
  output exec_pkg::flags_t   wb_flags
);

  import exec_pkg::*;

  reg_idx_t rd_a_addr;
  reg_idx_t rd_b_addr;
  data_t    rd_a_data;
  data_t    rd_b_data;
  logic     rd_a_pending;
  logic     rd_b_pending;
  logic     alloc;
  reg_idx_t alloc_reg;
  logic     alloc_pending;

  issue_if iss_bus ();
  wb_if    wb_bus ();

  reg_state u_reg_state (
    .clk           (clk),
    .rst           (rst),
    .rd_a_addr     (rd_a_addr),
    .rd_b_addr     (rd_b_addr),
    .rd_a_data     (rd_a_data),
    .rd_b_data     (rd_b_data),
    .rd_a_pending  (rd_a_pending),
    .rd_b_pending  (rd_b_pending),
    .alloc         (alloc),
    .alloc_reg     (alloc_reg),
    .alloc_pending (alloc_pending),
    .wb            (wb_bus.reg_side)
  );

  issue_queue u_issue_queue (
    .clk           (clk),
    .rst           (rst),
    .insert        (insert),
    .op            (op),
    .src_a         (src_a),
    .src_b         (src_b),
    .dst           (dst),
    .imm           (imm),
    .use_imm       (use_imm),
    .busy          (busy),
    .rd_a_addr     (rd_a_addr),
    .rd_b_addr     (rd_b_addr),
    .rd_a_data     (rd_a_data),
    .rd_b_data     (rd_b_data),
    .rd_a_pending  (rd_a_pending),
    .rd_b_pending  (rd_b_pending),
    .alloc         (alloc),
    .alloc_reg     (alloc_reg),
    .alloc_pending (alloc_pending),
    .wb            (wb_bus.snoop),
    .iss           (iss_bus.queue)
  );

  alu u_alu (
    .clk (clk),
    .rst (rst),
    .iss (iss_bus.alu),
    .wb  (wb_bus.src)
  );

  assign wb_valid = wb_bus.valid;
  assign wb_reg   = wb_bus.dst;
  assign wb_data  = wb_bus.data;
  assign wb_flags = wb_bus.flags;

endmodule

//--- testbench/tb_exec_core.sv
module tb_exec_core;
  timeunit 1ns;
  timeprecision 100ps;

  import exec_pkg::*;

  logic     clk;
  logic     rst;
  logic     insert;
  alu_op_t  op;
  reg_idx_t src_a;
  reg_idx_t src_b;
  reg_idx_t dst;
  data_t    imm;
  logic     use_imm;
  logic     busy;
  logic     wb_valid;
  reg_idx_t wb_reg;
  data_t    wb_data;
  flags_t   wb_flags;

  // shadow register file in program order, one write per register in flight
  data_t           shadow    [nreg];
  flags_t          exp_flags [nreg];
  logic [nreg-1:0] tb_pending;
  int              age [nreg];
  int              outstanding;
  int              in_queue;
  logic            exp_busy;
  logic            overdue;
  int              seed;

  exec_core dut0 (
    .clk      (clk),
    .rst      (rst),
    .insert   (insert),
    .op       (op),
    .src_a    (src_a),
    .src_b    (src_b),
    .dst      (dst),
    .imm      (imm),
    .use_imm  (use_imm),
    .busy     (busy),
    .wb_valid (wb_valid),
    .wb_reg   (wb_reg),
    .wb_data  (wb_data),
    .wb_flags (wb_flags)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_value(input string sig, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    $display("ERRORS FOUND");
    $display("FAIL time %0t %s expected %h actual %h", $time, sig, exp_v, act_v);
    $fatal(1, "value mismatch");
  endtask

  task automatic report_text(input string what);
    $display("ERRORS FOUND");
    $display("%s, at time %0t", what, $time);
    $fatal(1, "check failed");
  endtask

  function automatic void ref_alu(input alu_op_t f, input data_t a, input data_t b,
                                  output data_t r, output flags_t fl);
    logic [32:0] wide;
    r  = '0;
    fl = '0;
    case (f)
      op_add: begin
        wide        = 33'(a) + 33'(b);
        r           = wide[31:0];
        fl.carry    = wide[32];
        fl.overflow = (a[31] & b[31] & ~r[31]) | (~a[31] & ~b[31] & r[31]);
      end
      op_sub: begin
        r           = a - b;
        fl.carry    = (a >= b);  // no borrow
        fl.overflow = (a[31] ^ b[31]) & (a[31] ^ r[31]);
      end
      op_and:  r = a & b;
      op_xor:  r = a ^ b;
      op_or:   r = a | b;
      op_shl:  r = a << b[4:0];
      op_shr:  r = a >> b[4:0];
      op_sar:  r = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
      op_sxtb: r = a[7] ? (a | 32'hffff_ff00) : (a & 32'h0000_00ff);
      op_sxth: r = a[15] ? (a | 32'hffff_0000) : (a & 32'h0000_ffff);
      op_bswap: begin
        for (int k = 0; k < 4; k++) r[8*k +: 8] = a[8*(3-k) +: 8];
      end
      op_movi: r = b;
      default: r = '0;
    endcase
    fl.zero = (r == 32'h0);
    fl.sign = r[31];
  endfunction

  always @(posedge clk) begin
    data_t  a;
    data_t  b;
    data_t  r;
    flags_t fl;
    if (rst) begin
      for (int i = 0; i < nreg; i++) shadow[i] <= '0;
      tb_pending  <= '0;
      outstanding <= 0;
    end else begin
      if (wb_valid) tb_pending[wb_reg] <= 1'b0;
      if (insert) begin
        a = shadow[src_a];
        b = use_imm ? imm : shadow[src_b];
        ref_alu(op, a, b, r, fl);
        shadow[dst]     <= r;
        exp_flags[dst]  <= fl;
        tb_pending[dst] <= 1'b1;
      end
      outstanding <= outstanding + (insert ? 1 : 0) - (wb_valid ? 1 : 0);
    end
  end

  // cycles each register has waited for its result
  always @(posedge clk) begin
    for (int i = 0; i < nreg; i++) begin
      if (rst || !tb_pending[i]) age[i] <= 0;
      else age[i] <= age[i] + 1;
    end
  end

  always_comb begin
    overdue = 1'b0;
    for (int i = 0; i < nreg; i++) begin
      if (age[i] > 64) overdue = 1'b1;
    end
  end

  assign in_queue = outstanding - (wb_valid ? 1 : 0);  // one may sit in the wb stage
  assign exp_busy = tb_pending[dst] || in_queue >= iq_depth;

  a_reset_wb: assert property (@(posedge clk) $fell(rst) |-> !wb_valid)
    else report_value("wb_valid", 32'd0, 32'($sampled(wb_valid)));
  a_busy: assert property (@(posedge clk) disable iff (rst) busy == exp_busy)
    else report_value("busy", 32'($sampled(exp_busy)), 32'($sampled(busy)));
  a_wb_data: assert property (@(posedge clk) disable iff (rst)
    wb_valid |-> wb_data == shadow[wb_reg])
    else report_value("wb_data", $sampled(shadow[wb_reg]), $sampled(wb_data));
  a_wb_flags: assert property (@(posedge clk) disable iff (rst)
    wb_valid |-> wb_flags == exp_flags[wb_reg])
    else report_value("wb_flags", 32'($sampled(exp_flags[wb_reg])), 32'($sampled(wb_flags)));
  a_wb_target: assert property (@(posedge clk) disable iff (rst)
    wb_valid |-> tb_pending[wb_reg])
    else report_text("writeback to a register with nothing outstanding");
  a_latency: assert property (@(posedge clk) disable iff (rst) !overdue)
    else report_text("an insert got no writeback within 64 cycles");

  function automatic reg_idx_t rand_reg();
    return reg_idx_t'($random(seed));
  endfunction

  function automatic alu_op_t rand_op();
    return alu_op_t'(4'({$random(seed)} % 12));
  endfunction

  // corner values now and then for carry and overflow
  function automatic data_t rand_data();
    case ({$random(seed)} % 6)
      0:       return 32'h7fff_ffff;
      1:       return 32'h8000_0000;
      2:       return 32'hffff_ffff;
      3:       return 32'h0000_0000;
      default: return data_t'($random(seed));
    endcase
  endfunction

  // called at a falling edge, returns at a later falling edge
  task automatic send_insert(input alu_op_t f, input reg_idx_t ra, input reg_idx_t rb,
                             input reg_idx_t rd, input data_t value, input logic with_imm);
    int waited;
    waited  = 0;
    op      = f;
    src_a   = ra;
    src_b   = rb;
    dst     = rd;
    imm     = value;
    use_imm = with_imm;
    insert  = 1'b0;
    while (tb_pending[rd] || in_queue >= iq_depth) begin
      @(negedge clk);
      waited++;
      if (waited > 64) report_text("no insert slot opened within 64 cycles");
    end
    insert = 1'b1;
    @(negedge clk);
    insert = 1'b0;
  endtask

  task automatic drain_all();
    int waited;
    waited = 0;
    while (outstanding != 0) begin
      @(negedge clk);
      waited++;
      if (waited > 200) report_text("outstanding work did not drain");
    end
  endtask

  // r0..r7 chained back to back, then eight readers of r7 fill the queue
  task automatic run_chain();
    for (int k = 0; k < 7; k++) begin
      send_insert(rand_op(), reg_idx_t'(k), reg_idx_t'(k), reg_idx_t'(k + 1), rand_data(), 1'b0);
    end
    for (int k = 8; k < 16; k++) begin
      send_insert(rand_op(), 4'd7, rand_reg(), reg_idx_t'(k), rand_data(), 1'b0);
    end
  endtask

  initial begin
    seed    = 32'hb59c_079f;
    rst     = 1'b1;
    insert  = 1'b0;
    op      = op_add;
    src_a   = '0;
    src_b   = '0;
    dst     = '0;
    imm     = '0;
    use_imm = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // zero registers straight after reset
    send_insert(op_add, 4'd1, 4'd2, 4'd3, 32'h0, 1'b0);
    send_insert(op_sub, 4'd4, 4'd5, 4'd6, 32'h0, 1'b0);
    send_insert(op_bswap, 4'd3, 4'd6, 4'd9, 32'h0, 1'b0);
    drain_all();

    for (int r = 0; r < nreg; r++) begin
      send_insert(op_movi, 4'd0, 4'd0, reg_idx_t'(r), rand_data(), 1'b1);
    end
    for (int k = 0; k < 12; k++) begin
      send_insert(alu_op_t'(k), rand_reg(), rand_reg(), rand_reg(), rand_data(), 1'b0);
      send_insert(alu_op_t'(k), rand_reg(), rand_reg(), rand_reg(), rand_data(), 1'b1);
    end
    for (int n = 0; n < 300; n++) begin
      send_insert(rand_op(), rand_reg(), rand_reg(), rand_reg(), rand_data(),
                  $random(seed) % 2 == 0);
    end
    for (int n = 0; n < 4; n++) begin
      drain_all();
      run_chain();
    end
    drain_all();
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- flist.f
verilog/exec_pkg.sv
verilog/issue_if.sv
verilog/wb_if.sv
verilog/reg_state.sv
verilog/issue_queue.sv
verilog/alu.sv
verilog/exec_core.sv
testbench/tb_exec_core.sv
